/* hdl/bpred_consts.svh */
`ifndef BPRED_CONSTS_SVH
`define BPRED_CONSTS_SVH

// Address and data width of the core
`define BPRED_XLEN 32

// Direct-mapped BTB geometry
`define BPRED_BTB_DEPTH 16
`define BPRED_BTB_IDX_W 4
// Index sits just above the word offset, pc[5:2]
`define BPRED_BTB_IDX_LSB 2
// Tag is every pc bit above the index
`define BPRED_BTB_TAG_W (`BPRED_XLEN - `BPRED_BTB_IDX_LSB - `BPRED_BTB_IDX_W)

// Return address stack entries, power of two
`define BPRED_RAS_DEPTH 4

`endif

/* hdl/rv_inst_pkg.sv */
`default_nettype none

package rv_inst_pkg;

  // Control-flow class of the instruction sitting in EX
  typedef enum logic [1:0] {
    CLS_NONE   = 2'd0,
    CLS_BRANCH = 2'd1,
    CLS_JAL    = 2'd2,
    CLS_JALR   = 2'd3
  } inst_class_e;

  // Architectural register index
  typedef logic [4:0] reg_idx_t;

  localparam reg_idx_t REG_ZERO = 5'd0;
  // Link registers by the standard calling convention
  localparam reg_idx_t REG_RA = 5'd1;
  localparam reg_idx_t REG_T0 = 5'd5;

  // True when rd names one of the link registers
  function automatic logic is_link_reg(input reg_idx_t rd);
    return (rd == REG_RA) || (rd == REG_T0);
  endfunction

endpackage

`default_nettype wire

/* hdl/bpred_pkg.sv */
`default_nettype none

package bpred_pkg;

  // 2-bit saturating counter, ordered so taken is the upper half
  typedef enum logic [1:0] {
    CTR_STRONG_NT = 2'd0,
    CTR_WEAK_NT   = 2'd1,
    CTR_WEAK_T    = 2'd2,
    CTR_STRONG_T  = 2'd3
  } ctr_e;

  // Counter predicts taken from weak taken upward
  function automatic logic ctr_taken(input ctr_e ctr);
    return ctr >= CTR_WEAK_T;
  endfunction

  // One saturating step toward the resolved outcome
  function automatic ctr_e ctr_step(input ctr_e ctr, input logic taken);
    ctr_e nxt;
    nxt = ctr;
    if (taken && (ctr != CTR_STRONG_T)) begin
      nxt = ctr_e'(ctr + 2'd1);
    end else if (!taken && (ctr != CTR_STRONG_NT)) begin
      nxt = ctr_e'(ctr - 2'd1);
    end
    return nxt;
  endfunction

  // Fresh entries start weak in the direction just seen
  function automatic ctr_e ctr_alloc(input logic taken);
    return taken ? CTR_WEAK_T : CTR_WEAK_NT;
  endfunction

endpackage

`default_nettype wire

/* hdl/bpred_ex.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bpred_consts.svh"

module bpred_ex (
  input  logic                     valid_ex,
  input  rv_inst_pkg::inst_class_e inst_class_ex,
  input  rv_inst_pkg::reg_idx_t    rd_ex,
  input  logic                     branch_taken_ex,
  input  logic [`BPRED_XLEN-1:0]   pc_ex,
  input  logic [`BPRED_XLEN-1:0]   jb_target_ex,
  input  logic                     bpred_taken_ex,
  input  logic [`BPRED_XLEN-1:0]   pred_target_ex,
  output logic                     btb_update_en,
  output logic [`BPRED_XLEN-1:0]   btb_update_pc,
  output logic [`BPRED_XLEN-1:0]   btb_update_target,
  output logic                     btb_update_taken,
  output logic                     btb_update_is_ret,
  output logic                     btb_update_is_jal,
  output logic                     ras_push,
  output logic                     ras_pop,
  output logic [`BPRED_XLEN-1:0]   ras_call_pc,
  output logic                     resolved_valid,
  output logic                     resolved_taken,
  output logic [`BPRED_XLEN-1:0]   resolved_target,
  output logic [`BPRED_XLEN-1:0]   resolved_pc,
  output logic                     resolved_pred_taken,
  output logic [`BPRED_XLEN-1:0]   resolved_pred_target
);
  import rv_inst_pkg::*;

  logic is_jal;
  logic is_jalr;
  logic is_ret;
  logic is_call;
  logic is_uncond;

  assign is_jal  = (inst_class_ex == CLS_JAL);
  assign is_jalr = (inst_class_ex == CLS_JALR);

  // JALR that discards the link is treated as a return
  assign is_ret = is_jalr && (rd_ex == REG_ZERO);
  // Any jump that writes ra or t0 is a call
  assign is_call = (is_jal || is_jalr) && is_link_reg(rd_ex);
  // Jumps always redirect, branches depend on the compare
  assign is_uncond = is_jal || is_jalr;

  // RAS follows the call/return convention
  assign ras_push    = valid_ex && is_call;
  assign ras_pop     = valid_ex && is_ret;
  assign ras_call_pc = pc_ex;

  // Plain indirect jumps stay out of the BTB, target is register based
  assign btb_update_en     = valid_ex && ((inst_class_ex == CLS_BRANCH) || is_jal || is_ret);
  assign btb_update_pc     = pc_ex;
  assign btb_update_target = jb_target_ex;
  assign btb_update_taken  = (is_jal || is_ret) ? 1'b1 : branch_taken_ex;
  assign btb_update_is_ret = is_ret;
  assign btb_update_is_jal = is_jal;

  // Actual outcome plus the prediction it carried, compared in MEM
  assign resolved_valid       = valid_ex && (inst_class_ex != CLS_NONE);
  assign resolved_taken       = is_uncond ? 1'b1 : branch_taken_ex;
  assign resolved_target      = jb_target_ex;
  assign resolved_pc          = pc_ex;
  assign resolved_pred_taken  = bpred_taken_ex;
  assign resolved_pred_target = pred_target_ex;

endmodule

`default_nettype wire

/* hdl/bpred_btb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bpred_consts.svh"

module bpred_btb (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic [`BPRED_XLEN-1:0] fetch_pc,
  input  logic                   btb_update_en,
  input  logic [`BPRED_XLEN-1:0] btb_update_pc,
  input  logic [`BPRED_XLEN-1:0] btb_update_target,
  input  logic                   btb_update_taken,
  input  logic                   btb_update_is_ret,
  input  logic                   btb_update_is_jal,
  output logic                   btb_hit,
  output logic [`BPRED_XLEN-1:0] btb_target,
  output logic                   btb_taken,
  output logic                   btb_is_ret
);
  import bpred_pkg::*;

  localparam int XLEN    = `BPRED_XLEN;
  localparam int DEPTH   = `BPRED_BTB_DEPTH;
  localparam int IDX_W   = `BPRED_BTB_IDX_W;
  localparam int IDX_LSB = `BPRED_BTB_IDX_LSB;
  localparam int TAG_W   = `BPRED_BTB_TAG_W;

  // Only the valid bits are cleared, the rest is guarded by them
  logic [DEPTH-1:0] valid_q;
  logic [TAG_W-1:0] tag_q    [DEPTH];
  logic [XLEN-1:0]  target_q [DEPTH];
  ctr_e             ctr_q    [DEPTH];
  logic [DEPTH-1:0] is_ret_q;
  logic [DEPTH-1:0] is_jal_q;

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;
  logic             wr_match;
  ctr_e             wr_ctr;

  // Fetch lookup, same cycle
  assign rd_idx = fetch_pc[IDX_LSB +: IDX_W];
  assign rd_tag = fetch_pc[XLEN-1 -: TAG_W];

  assign btb_hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign btb_target = target_q[rd_idx];
  // Unconditional jumps never predict not taken
  assign btb_taken  = is_jal_q[rd_idx] || ctr_taken(ctr_q[rd_idx]);
  assign btb_is_ret = is_ret_q[rd_idx];

  // Update side
  assign wr_idx   = btb_update_pc[IDX_LSB +: IDX_W];
  assign wr_tag   = btb_update_pc[XLEN-1 -: TAG_W];
  assign wr_match = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

  // Train the existing counter, or restart it on replacement
  always_comb begin
    if (wr_match) begin
      wr_ctr = ctr_step(ctr_q[wr_idx], btb_update_taken);
    end else begin
      wr_ctr = ctr_alloc(btb_update_taken);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (btb_update_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Tag, target and flags rewritten on every update
  always_ff @(posedge clk) begin
    if (btb_update_en) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= btb_update_target;
      ctr_q[wr_idx]    <= wr_ctr;
      is_ret_q[wr_idx] <= btb_update_is_ret;
      is_jal_q[wr_idx] <= btb_update_is_jal;
    end
  end

endmodule

`default_nettype wire

/* hdl/bpred_ras.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bpred_consts.svh"

module bpred_ras (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   ras_push,
  input  logic                   ras_pop,
  input  logic [`BPRED_XLEN-1:0] ras_call_pc,
  input  logic                   btb_hit,
  input  logic [`BPRED_XLEN-1:0] btb_target,
  input  logic                   btb_taken,
  input  logic                   btb_is_ret,
  output logic                   pred_taken,
  output logic [`BPRED_XLEN-1:0] pred_target
);
  localparam int XLEN  = `BPRED_XLEN;
  localparam int DEPTH = `BPRED_RAS_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [XLEN-1:0]  stack_q [DEPTH];
  // Points at the current top entry
  logic [PTR_W-1:0] top_q;
  logic [CNT_W-1:0] count_q;
  logic [PTR_W-1:0] push_ptr;
  logic             empty;

  // Pointer wraps, so a push when full overwrites the oldest entry
  assign push_ptr = top_q + 1'b1;
  assign empty    = (count_q == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      top_q   <= '0;
      count_q <= '0;
    end else if (ras_push) begin
      top_q <= push_ptr;
      // Depth saturates, older entries are silently lost
      if (count_q != CNT_W'(DEPTH)) begin
        count_q <= count_q + 1'b1;
      end
    end else if (ras_pop && !empty) begin
      top_q   <= top_q - 1'b1;
      count_q <= count_q - 1'b1;
    end
  end

  // Return address is the instruction after the call
  always_ff @(posedge clk) begin
    if (ras_push) begin
      stack_q[push_ptr] <= ras_call_pc + XLEN'(4);
    end
  end

  assign pred_taken = btb_hit && btb_taken;
  // Stack overrides the stored target for return hits
  assign pred_target = (btb_hit && btb_is_ret && !empty) ? stack_q[top_q] : btb_target;

endmodule

`default_nettype wire

/* hdl/bpred_mem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bpred_consts.svh"

module bpred_mem (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   resolved_valid,
  input  logic                   resolved_taken,
  input  logic [`BPRED_XLEN-1:0] resolved_target,
  input  logic [`BPRED_XLEN-1:0] resolved_pc,
  input  logic                   resolved_pred_taken,
  input  logic [`BPRED_XLEN-1:0] resolved_pred_target,
  output logic                   mispredicted_mem,
  output logic [`BPRED_XLEN-1:0] redirect_pc_mem
);
  localparam int XLEN = `BPRED_XLEN;

  // EX/MEM register
  logic            valid_q;
  logic            taken_q;
  logic            pred_taken_q;
  logic [XLEN-1:0] target_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pred_target_q;

  logic dir_miss;
  logic tgt_miss;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= resolved_valid;
    end
  end

  // Payload only means something while valid_q is set
  always_ff @(posedge clk) begin
    taken_q       <= resolved_taken;
    pred_taken_q  <= resolved_pred_taken;
    target_q      <= resolved_target;
    pc_q          <= resolved_pc;
    pred_target_q <= resolved_pred_target;
  end

  // Direction disagreed
  assign dir_miss = (taken_q != pred_taken_q);
  // Both taken but to different places
  assign tgt_miss = taken_q && pred_taken_q && (target_q != pred_target_q);

  // Strobe lasts one cycle since valid_q follows the EX strobe
  assign mispredicted_mem = valid_q && (dir_miss || tgt_miss);

  // Correct path: target when taken, else fall through
  assign redirect_pc_mem = taken_q ? target_q : pc_q + XLEN'(4);

endmodule

`default_nettype wire

/* hdl/bpred_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bpred_consts.svh"

module bpred_top (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [`BPRED_XLEN-1:0]   fetch_pc,
  output logic                     pred_taken,
  output logic [`BPRED_XLEN-1:0]   pred_target,
  input  logic                     valid_ex,
  input  rv_inst_pkg::inst_class_e inst_class_ex,
  input  rv_inst_pkg::reg_idx_t    rd_ex,
  input  logic                     branch_taken_ex,
  input  logic [`BPRED_XLEN-1:0]   pc_ex,
  input  logic [`BPRED_XLEN-1:0]   jb_target_ex,
  input  logic                     bpred_taken_ex,
  input  logic [`BPRED_XLEN-1:0]   pred_target_ex,
  output logic                     mispredicted_mem,
  output logic [`BPRED_XLEN-1:0]   redirect_pc_mem
);
  // EX to BTB
  logic                   btb_update_en;
  logic [`BPRED_XLEN-1:0] btb_update_pc;
  logic [`BPRED_XLEN-1:0] btb_update_target;
  logic                   btb_update_taken;
  logic                   btb_update_is_ret;
  logic                   btb_update_is_jal;
  // EX to RAS
  logic                   ras_push;
  logic                   ras_pop;
  logic [`BPRED_XLEN-1:0] ras_call_pc;
  // EX to MEM
  logic                   resolved_valid;
  logic                   resolved_taken;
  logic [`BPRED_XLEN-1:0] resolved_target;
  logic [`BPRED_XLEN-1:0] resolved_pc;
  logic                   resolved_pred_taken;
  logic [`BPRED_XLEN-1:0] resolved_pred_target;
  // BTB lookup into target selection
  logic                   btb_hit;
  logic [`BPRED_XLEN-1:0] btb_target;
  logic                   btb_taken;
  logic                   btb_is_ret;

  bpred_ex i_ex (.*);

  bpred_btb i_btb (.*);

  // RAS also picks the final fetch target
  bpred_ras i_ras (.*);

  bpred_mem i_mem (.*);

endmodule

`default_nettype wire

/* bench/bpred_sva.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bpred_consts.svh"

module bpred_sva (
  input wire logic                     clk,
  input wire logic                     arst_n,
  input wire logic                     valid_ex,
  input wire rv_inst_pkg::inst_class_e inst_class_ex,
  input wire logic [`BPRED_XLEN-1:0]   fetch_pc,
  input wire logic [`BPRED_XLEN-1:0]   pc_ex,
  input wire logic                     pred_taken,
  input wire logic                     mispredicted_mem
);
  import rv_inst_pkg::*;

  // No strobe while held in reset
  a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !mispredicted_mem)
    else $error("mispredicted_mem high during reset");

  // Empty EX slot gives a quiet MEM stage next cycle
  a_idle_no_miss: assert property (@(posedge clk) disable iff (!arst_n)
    !valid_ex |=> !mispredicted_mem)
    else $error("mispredicted_mem high after an idle EX cycle");

  // A JAL just written predicts taken when fetched again
  a_jal_taken: assert property (@(posedge clk) disable iff (!arst_n)
    (valid_ex && (inst_class_ex == CLS_JAL)) |=> ((fetch_pc != $past(pc_ex)) || pred_taken))
    else $error("JAL pc looked up after its update did not predict taken");

endmodule

bind bpred_top bpred_sva i_sva (.*);

`default_nettype wire

/* bench/bpred_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bpred_consts.svh"

module bpred_tb;
  import rv_inst_pkg::*;

  localparam int XLEN = `BPRED_XLEN;
  localparam int DEPTH = `BPRED_BTB_DEPTH;
  localparam int RASD = `BPRED_RAS_DEPTH;
  localparam int TAG_LSB = `BPRED_BTB_IDX_LSB + `BPRED_BTB_IDX_W;
  // Cycles per test including the drain step
  localparam int LEN_COLD = 14;
  localparam int LEN_TRAIN = 62;
  localparam int LEN_MISP = 52;
  localparam int LEN_CALL = 24;
  localparam int LEN_INV = 14;
  // Reset and the idle cycle between tests on top
  localparam int LIMIT = LEN_COLD + LEN_TRAIN + LEN_MISP + LEN_CALL + LEN_INV + 10 + 100;

  logic clk;
  logic arst_n;
  logic [XLEN-1:0] fetch_pc;
  logic pred_taken;
  logic [XLEN-1:0] pred_target;
  logic valid_ex;
  inst_class_e inst_class_ex;
  reg_idx_t rd_ex;
  logic branch_taken_ex;
  logic [XLEN-1:0] pc_ex;
  logic [XLEN-1:0] jb_target_ex;
  logic bpred_taken_ex;
  logic [XLEN-1:0] pred_target_ex;
  logic mispredicted_mem;
  logic [XLEN-1:0] redirect_pc_mem;

  // Reference BTB and RAS state
  logic m_valid [DEPTH];
  logic [XLEN-1:0] m_tag [DEPTH];
  logic [XLEN-1:0] m_target [DEPTH];
  int m_ctr [DEPTH];
  logic m_ret [DEPTH];
  logic m_jal [DEPTH];
  logic [XLEN-1:0] m_ras [RASD];
  int m_top;
  int m_cnt;

  // Expected fetch result for the cycle being driven
  logic exp_taken = 1'b0;
  logic [XLEN-1:0] exp_target;
  // MEM expectations for the EX cycle and for the cycle after it
  logic ex_valid = 1'b0;
  logic ex_mis = 1'b0;
  logic [XLEN-1:0] ex_redir;
  logic mem_valid = 1'b0;
  logic mem_mis = 1'b0;
  logic [XLEN-1:0] mem_redir;

  logic run = 1'b0;
  string cur_test = "reset";
  int test_errs = 0;
  int test_checks = 0;
  int n_tests = 0;
  int n_checks = 0;
  int n_errors = 0;
  int cycles = 0;
  logic [XLEN-1:0] train_pc [4];
  logic [XLEN-1:0] pc_r;
  logic [XLEN-1:0] tgt_r;

  bpred_top i_bpred_top (.*);

  always #20 clk = ~clk;

  // Clear the model to the post-reset state
  function automatic void model_reset();
    for (int i = 0; i < DEPTH; i++) begin
      m_valid[i] = 1'b0;
      m_tag[i] = '0;
      m_target[i] = '0;
      m_ctr[i] = 0;
      m_ret[i] = 1'b0;
      m_jal[i] = 1'b0;
    end
    m_top = 0;
    m_cnt = 0;
  endfunction

  // Fetch prediction for a pc from the model
  function automatic void predict(input logic [XLEN-1:0] fpc, output logic tk,
                                  output logic [XLEN-1:0] tgt);
    int idx;
    logic hit;
    idx = (fpc >> `BPRED_BTB_IDX_LSB) % DEPTH;
    hit = m_valid[idx] && (m_tag[idx] == (fpc >> TAG_LSB));
    // Jumps always taken, branches from upper half of the counter
    tk = hit && (m_jal[idx] || (m_ctr[idx] >= 2));
    tgt = (hit && m_ret[idx] && (m_cnt > 0)) ? m_ras[m_top] : m_target[idx];
  endfunction

  // MEM stage rule for one EX instruction
  function automatic void mem_expect(input logic v, input inst_class_e cls, input logic bt,
                                     input logic [XLEN-1:0] tgt, input logic [XLEN-1:0] pc,
                                     input logic ptk, input logic [XLEN-1:0] ptgt,
                                     output logic val, output logic mis,
                                     output logic [XLEN-1:0] redir);
    logic act;
    act = ((cls == CLS_JAL) || (cls == CLS_JALR)) ? 1'b1 : bt;
    val = v && (cls != CLS_NONE);
    mis = val && ((act != ptk) || (act && ptk && (tgt != ptgt)));
    redir = act ? tgt : pc + 32'd4;
  endfunction

  // Apply one EX instruction to the BTB and RAS model
  function automatic void model_update(input logic v, input inst_class_e cls, input reg_idx_t rd,
                                       input logic bt, input logic [XLEN-1:0] pc,
                                       input logic [XLEN-1:0] tgt);
    int idx;
    logic is_ret;
    logic is_call;
    logic tk;
    idx = (pc >> `BPRED_BTB_IDX_LSB) % DEPTH;
    is_ret = (cls == CLS_JALR) && (rd == 5'd0);
    is_call = ((cls == CLS_JAL) || (cls == CLS_JALR)) && ((rd == 5'd1) || (rd == 5'd5));
    tk = ((cls == CLS_JAL) || is_ret) ? 1'b1 : bt;
    if (v && ((cls == CLS_BRANCH) || (cls == CLS_JAL) || is_ret)) begin
      // Hit trains by one saturating step, miss restarts weak
      if (m_valid[idx] && (m_tag[idx] == (pc >> TAG_LSB))) begin
        m_ctr[idx] = tk ? ((m_ctr[idx] == 3) ? 3 : m_ctr[idx] + 1)
                        : ((m_ctr[idx] == 0) ? 0 : m_ctr[idx] - 1);
      end else begin
        m_ctr[idx] = tk ? 2 : 1;
      end
      m_valid[idx] = 1'b1;
      m_tag[idx] = pc >> TAG_LSB;
      m_target[idx] = tgt;
      m_ret[idx] = is_ret;
      m_jal[idx] = (cls == CLS_JAL);
    end
    // Circular stack drops its oldest entry when full
    if (v && is_call) begin
      m_top = (m_top + 1) % RASD;
      m_ras[m_top] = pc + 32'd4;
      if (m_cnt < RASD) begin
        m_cnt++;
      end
    end else if (v && is_ret && (m_cnt > 0)) begin
      m_top = (m_top + RASD - 1) % RASD;
      m_cnt--;
    end
  endfunction

  // Drive one cycle on the falling edge, then advance the model
  task automatic step(input logic v, input inst_class_e cls, input reg_idx_t rd,
                      input logic bt, input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tgt,
                      input logic ptk, input logic [XLEN-1:0] ptgt,
                      input logic [XLEN-1:0] fpc);
    @(negedge clk);
    fetch_pc = fpc;
    valid_ex = v;
    inst_class_ex = cls;
    rd_ex = rd;
    branch_taken_ex = bt;
    pc_ex = pc;
    jb_target_ex = tgt;
    bpred_taken_ex = ptk;
    pred_target_ex = ptgt;
    predict(fpc, exp_taken, exp_target);
    mem_expect(v, cls, bt, tgt, pc, ptk, ptgt, ex_valid, ex_mis, ex_redir);
    model_update(v, cls, rd, bt, pc, tgt);
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_errs = 0;
    test_checks = 0;
  endtask

  // Idle step lets the last MEM result get checked
  task automatic end_test();
    step(1'b0, CLS_NONE, '0, 1'b0, '0, '0, 1'b0, '0, '0);
    @(negedge clk);
    n_tests++;
    $display("test %-10s done: %0d checks, %0d errors", cur_test, test_checks, test_errs);
  endtask

  task automatic flag_mismatch(input string what, input logic [XLEN-1:0] exp_v,
                               input logic [XLEN-1:0] act_v);
    $display("[FAIL] %s: %s expected %h actual %h", cur_test, what, exp_v, act_v);
    test_errs++;
    n_errors++;
  endtask

  // Compare on every rising edge, before the flops update
  always @(posedge clk) begin
    if (run) begin
      test_checks++;
      n_checks++;
      if (pred_taken !== exp_taken) begin
        flag_mismatch("pred_taken", XLEN'(exp_taken), XLEN'(pred_taken));
      end
      if (exp_taken && (pred_target !== exp_target)) begin
        flag_mismatch("pred_target", exp_target, pred_target);
      end
      if (mispredicted_mem !== mem_mis) begin
        flag_mismatch("mispredicted_mem", XLEN'(mem_mis), XLEN'(mispredicted_mem));
      end
      if (mem_valid && (redirect_pc_mem !== mem_redir)) begin
        flag_mismatch("redirect_pc_mem", mem_redir, redirect_pc_mem);
      end
      mem_valid = ex_valid;
      mem_mis = ex_mis;
      mem_redir = ex_redir;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Timeout after %0d cycles, test %s never finished", cycles, cur_test);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'ha4fe_e0ea));
    clk = 1'b1;
    arst_n = 1'b1;
    fetch_pc = '0;
    valid_ex = 1'b0;
    inst_class_ex = CLS_NONE;
    rd_ex = '0;
    branch_taken_ex = 1'b0;
    pc_ex = '0;
    jb_target_ex = '0;
    bpred_taken_ex = 1'b0;
    pred_target_ex = '0;
    // Two pairs share an index with different tags
    train_pc[0] = 32'h0000_1000;
    train_pc[1] = 32'h0000_1040;
    train_pc[2] = 32'h0000_2008;
    train_pc[3] = 32'h0000_2048;
    model_reset();
    @(negedge clk);
    arst_n = 1'b0;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
    run = 1'b1;

    // Empty BTB, then one taken branch allocates
    begin_test("cold_start");
    for (int i = 0; i < 8; i++) begin
      step(1'b0, CLS_NONE, '0, 1'b0, '0, '0, 1'b0, '0, $urandom() & 32'hffff_fffc);
    end
    step(1'b1, CLS_BRANCH, '0, 1'b1, 32'h100, 32'h240, 1'b0, '0, 32'h100);
    step(1'b0, CLS_NONE, '0, 1'b0, '0, '0, 1'b0, '0, 32'h100);
    end_test();

    // Random outcomes on aliasing branch pcs
    begin_test("ctr_train");
    for (int i = 0; i < 60; i++) begin
      pc_r = train_pc[$urandom_range(0, 3)];
      step(1'b1, CLS_BRANCH, '0, 1'($urandom_range(0, 1)), pc_r, pc_r + 32'h80,
           1'($urandom_range(0, 1)), pc_r + 32'h80, train_pc[$urandom_range(0, 3)]);
    end
    end_test();

    // Random classes and carried predictions
    begin_test("mispredict");
    for (int i = 0; i < 50; i++) begin
      pc_r = 32'h4000 + ($urandom_range(0, 63) << 2);
      tgt_r = 32'h8000 + ($urandom_range(0, 15) << 2);
      step(1'b1, inst_class_e'($urandom_range(1, 3)), 5'($urandom_range(0, 7)),
           1'($urandom_range(0, 1)), pc_r, tgt_r, 1'($urandom_range(0, 1)),
           $urandom_range(0, 1) ? tgt_r : tgt_r + 32'd4, pc_r);
    end
    end_test();

    // Train a return, then read it back through the RAS
    begin_test("call_ret");
    step(1'b1, CLS_JAL, 5'd1, 1'b0, 32'h600, 32'h900, 1'b0, '0, 32'h940);
    // JAL just written is fetched again
    step(1'b1, CLS_JALR, 5'd0, 1'b0, 32'h940, 32'h604, 1'b0, '0, 32'h600);
    // Second call sits on another index so the return entry survives
    step(1'b1, CLS_JAL, 5'd1, 1'b0, 32'h710, 32'h900, 1'b0, '0, 32'h940);
    step(1'b0, CLS_NONE, '0, 1'b0, '0, '0, 1'b0, '0, 32'h940);
    // Drain the stack so the BTB target shows
    for (int i = 0; i < RASD + 1; i++) begin
      step(1'b1, CLS_JALR, 5'd0, 1'b0, 32'h940, 32'ha00, 1'b1, 32'ha00, 32'h940);
    end
    step(1'b0, CLS_NONE, '0, 1'b0, '0, '0, 1'b0, '0, 32'h940);
    // Overflow the stack, then pop it back down
    for (int i = 0; i < 6; i++) begin
      step(1'b1, CLS_JAL, (i % 2) ? 5'd5 : 5'd1, 1'b0, 32'h600 + 32'(i * 16), 32'h900,
           1'b1, 32'h900, 32'h940);
    end
    for (int i = 0; i < 5; i++) begin
      step(1'b1, CLS_JALR, 5'd0, 1'b0, 32'h940, 32'ha00, 1'b1, 32'ha00, 32'h940);
    end
    end_test();

    // Invalid cycles leave state alone, JALR x3 stays out of the BTB
    begin_test("invalid");
    for (int i = 0; i < 8; i++) begin
      pc_r = train_pc[$urandom_range(0, 3)];
      step(1'b0, inst_class_e'($urandom_range(0, 3)), 5'($urandom_range(0, 7)), 1'b1,
           pc_r, 32'h7000, 1'b0, '0, train_pc[$urandom_range(0, 3)]);
    end
    step(1'b1, CLS_JALR, 5'd3, 1'b0, 32'h3010, 32'h5000, 1'b0, '0, 32'h3010);
    step(1'b0, CLS_NONE, '0, 1'b0, '0, '0, 1'b0, '0, 32'h3010);
    // Return entry still shows the BTB target while the stack stays empty
    step(1'b0, CLS_NONE, '0, 1'b0, '0, '0, 1'b0, '0, 32'h940);
    end_test();

    run = 1'b0;
    $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/rv_inst_pkg.sv
hdl/bpred_pkg.sv
hdl/bpred_ex.sv
hdl/bpred_btb.sv
hdl/bpred_ras.sv
hdl/bpred_mem.sv
hdl/bpred_top.sv
bench/bpred_sva.sv
bench/bpred_tb.sv

/* Bender.yml */
package:
  name: bpred

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_inst_pkg.sv
      - hdl/bpred_pkg.sv
      - hdl/bpred_ex.sv
      - hdl/bpred_btb.sv
      - hdl/bpred_ras.sv
      - hdl/bpred_mem.sv
      - hdl/bpred_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/bpred_sva.sv
      - bench/bpred_tb.sv
